// ==== hdl/common_pkg.sv ====
package common_pkg;

   typedef logic [31:0] uint32;
   typedef logic [29:0] word_addr_t;
   typedef logic [3:0]  byte_mask_t;

   typedef struct packed {
      word_addr_t address;
      logic       mem_read;
      logic       mem_write;
      byte_mask_t mask_byte;
      uint32      write_data;
   } mem_bus_cmd_t;

   typedef struct packed {
      uint32 read_data;
   } mem_bus_result_t;

   // data memory region
   localparam word_addr_t DATA_MEM_BASE = 30'h0;
   localparam int DATA_MEM_WORDS = 1024;
   localparam int MEM_INDEX_W = $clog2(DATA_MEM_WORDS);

   typedef logic [MEM_INDEX_W-1:0] mem_index_t;

   // uart transmit register, a single word
   localparam word_addr_t UART_ADDR = 30'h800;
   localparam int UART_CLKS_PER_BIT = 4;
   localparam int UART_CNT_W = $clog2(UART_CLKS_PER_BIT);

   typedef logic [UART_CNT_W-1:0] uart_cnt_t;
   typedef logic [2:0]            uart_bit_idx_t;
   typedef logic [7:0]            uart_byte_t;

   typedef enum logic [1:0] {
      UART_IDLE,
      UART_START,
      UART_DATA,
      UART_STOP
   } uart_state_t;

endpackage

// ==== hdl/bus_interconnect.sv ====
`timescale 1ns/1ns

module bus_interconnect (
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic                          probe_mem,
   input  common_pkg::mem_bus_cmd_t      probe_cmd,
   input  common_pkg::mem_bus_cmd_t      cpu_cmd,
   output common_pkg::mem_bus_result_t   probe_result,
   output common_pkg::mem_bus_result_t   cpu_result,
   output common_pkg::mem_bus_cmd_t      mem_cmd,
   output common_pkg::mem_bus_cmd_t      uart_cmd,
   input  common_pkg::mem_bus_result_t   mem_result,
   input  common_pkg::mem_bus_result_t   uart_result,
   output logic                          invalid_address
);
   import common_pkg::*;

   mem_bus_cmd_t    sel_cmd;
   mem_bus_result_t sel_result;
   word_addr_t      mem_offset;
   logic            in_mem;
   logic            in_uart;
   logic            strobe;

   assign sel_cmd = probe_mem ? probe_cmd : cpu_cmd;

   // offset wraps for addresses below the base, so one compare covers the region
   assign mem_offset = sel_cmd.address - DATA_MEM_BASE;
   assign in_mem     = mem_offset < word_addr_t'(DATA_MEM_WORDS);
   assign in_uart    = sel_cmd.address == UART_ADDR;
   assign strobe     = sel_cmd.mem_read | sel_cmd.mem_write;

   always_comb begin
      mem_cmd            = sel_cmd;
      mem_cmd.mem_read   = sel_cmd.mem_read & in_mem;
      mem_cmd.mem_write  = sel_cmd.mem_write & in_mem;
      uart_cmd           = sel_cmd;
      uart_cmd.mem_read  = sel_cmd.mem_read & in_uart;
      uart_cmd.mem_write = sel_cmd.mem_write & in_uart;
   end

   always_comb begin
      if (in_mem) sel_result = mem_result;
      else if (in_uart) sel_result = uart_result;
      else sel_result = '0; // unmapped reads return zero
   end

   assign probe_result = probe_mem ? sel_result : '0;
   assign cpu_result   = probe_mem ? '0 : sel_result;

   assign invalid_address = strobe & ~in_mem & ~in_uart;

   // a master must never read and write in the same cycle
   a_one_strobe: assert property (@(posedge clk) disable iff (!arst_n)
      !(sel_cmd.mem_read && sel_cmd.mem_write));

endmodule

// ==== hdl/data_mem.sv ====
`timescale 1ns/1ns

module data_mem (
   input  logic                          clk,
   input  logic                          arst_n,
   input  common_pkg::mem_bus_cmd_t      bus_cmd,
   output common_pkg::mem_bus_result_t   bus_result,
   input  common_pkg::uint32             pc,
   output common_pkg::uint32             instruction
);
   import common_pkg::*;

   uint32      mem [DATA_MEM_WORDS];
   word_addr_t bus_offset;
   mem_index_t bus_index;
   word_addr_t fetch_addr;
   mem_index_t fetch_index;

   assign bus_offset = bus_cmd.address - DATA_MEM_BASE;
   assign bus_index  = bus_offset[MEM_INDEX_W-1:0];

   // pc is a byte address
   assign fetch_addr  = pc[31:2];
   assign fetch_index = fetch_addr[MEM_INDEX_W-1:0];

   always_ff @(posedge clk) begin
      if (bus_cmd.mem_write) begin
         for (int b = 0; b < 4; b++) begin
            if (bus_cmd.mask_byte[b]) begin
               mem[bus_index][8*b +: 8] <= bus_cmd.write_data[8*b +: 8];
            end
         end
      end
   end

   always_comb begin
      bus_result = '0;
      if (bus_cmd.mem_read) begin
         bus_result.read_data = mem[bus_index]; // same cycle read
      end
   end

   assign instruction = mem[fetch_index];

   // the interconnect only strobes addresses inside the region
   a_in_range: assert property (@(posedge clk) disable iff (!arst_n)
      (bus_cmd.mem_read || bus_cmd.mem_write) |-> bus_offset < word_addr_t'(DATA_MEM_WORDS));

endmodule

// ==== hdl/uart_tx_port.sv ====
`timescale 1ns/1ns

module uart_tx_port (
   input  logic                          clk,
   input  logic                          arst_n,
   input  common_pkg::mem_bus_cmd_t      bus_cmd,
   output common_pkg::mem_bus_result_t   bus_result,
   output logic                          uart_tx
);
   import common_pkg::*;

   uart_state_t   state;
   uart_cnt_t     clk_cnt;
   uart_bit_idx_t bit_idx;
   uart_byte_t    shift_reg;
   logic          bit_end;
   logic          busy;
   logic          accept;

   assign busy    = state != UART_IDLE;
   assign accept  = (state == UART_IDLE) && bus_cmd.mem_write; // writes while busy are dropped
   assign bit_end = clk_cnt == uart_cnt_t'(UART_CLKS_PER_BIT - 1);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state   <= UART_IDLE;
         clk_cnt <= '0;
         bit_idx <= '0;
         uart_tx <= 1'b1;
      end else begin
         clk_cnt <= (bit_end || !busy) ? '0 : clk_cnt + 1'b1;
         case (state)
            UART_IDLE: begin
               if (accept) begin
                  state   <= UART_START;
                  uart_tx <= 1'b0; // start bit
               end
            end
            UART_START: begin
               if (bit_end) begin
                  state   <= UART_DATA;
                  bit_idx <= '0;
                  uart_tx <= shift_reg[0];
               end
            end
            UART_DATA: begin
               if (bit_end) begin
                  if (bit_idx == 3'd7) begin
                     state   <= UART_STOP;
                     uart_tx <= 1'b1;
                  end else begin
                     bit_idx <= bit_idx + 1'b1;
                     uart_tx <= shift_reg[0];
                  end
               end
            end
            UART_STOP: begin
               if (bit_end) state <= UART_IDLE;
            end
            default: state <= UART_IDLE;
         endcase
      end
   end

   // lsb first, shifted as each bit goes out
   always_ff @(posedge clk) begin
      if (accept) shift_reg <= bus_cmd.write_data[7:0];
      else if (bit_end && (state == UART_START || state == UART_DATA)) shift_reg <= shift_reg >> 1;
   end

   always_comb begin
      bus_result = '0;
      if (bus_cmd.mem_read) bus_result.read_data = uint32'(busy);
   end

   a_idle_high: assert property (@(posedge clk) disable iff (!arst_n)
      state == UART_IDLE |-> uart_tx);

   a_leave_idle: assert property (@(posedge clk) disable iff (!arst_n)
      (state == UART_IDLE && !bus_cmd.mem_write) |=> state == UART_IDLE);

endmodule

// ==== hdl/platform_top.sv ====
`timescale 1ns/1ns

module platform_top (
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic                          probe_mem,
   input  common_pkg::mem_bus_cmd_t      probe_cmd,
   output common_pkg::mem_bus_result_t   probe_result,
   input  common_pkg::mem_bus_cmd_t      cpu_cmd,
   output common_pkg::mem_bus_result_t   cpu_result,
   input  common_pkg::uint32             pc,
   output common_pkg::uint32             instruction,
   output logic                          invalid_address,
   output logic                          uart_tx
);
   import common_pkg::*;

   mem_bus_cmd_t    mem_cmd;
   mem_bus_result_t mem_result;
   mem_bus_cmd_t    uart_cmd;
   mem_bus_result_t uart_result;

   bus_interconnect i_interconnect (
      .clk,
      .arst_n,
      .probe_mem,
      .probe_cmd,
      .cpu_cmd,
      .probe_result,
      .cpu_result,
      .mem_cmd,
      .uart_cmd,
      .mem_result,
      .uart_result,
      .invalid_address
   );

   data_mem i_data_mem (
      .clk,
      .arst_n,
      .bus_cmd    (mem_cmd),
      .bus_result (mem_result),
      .pc,
      .instruction
   );

   uart_tx_port i_uart_tx (
      .clk,
      .arst_n,
      .bus_cmd    (uart_cmd),
      .bus_result (uart_result),
      .uart_tx
   );

endmodule

// ==== testbench/tb_platform_top.sv ====
`timescale 1ns/1ns

module tb_platform_top;
   import common_pkg::*;

   localparam int CLK_PERIOD   = 40;
   localparam int DRIVE_DELAY  = 5;
   localparam int SAMPLE_DELAY = CLK_PERIOD - DRIVE_DELAY - 5;
   localparam int RESET_CYCLES = 4;
   localparam int FRAME_CYCLES = UART_CLKS_PER_BIT * 10;

   typedef struct packed {
      logic         probe_mem;
      mem_bus_cmd_t probe_cmd;
      mem_bus_cmd_t cpu_cmd;
      uint32        pc;
      logic         chk_data;
      uint32        exp_data;
      logic         exp_invalid;
      logic         chk_instr;
      uint32        exp_instr;
   } row_t;

   logic            clk;
   logic            arst_n;
   logic            probe_mem;
   mem_bus_cmd_t    probe_cmd;
   mem_bus_result_t probe_result;
   mem_bus_cmd_t    cpu_cmd;
   mem_bus_result_t cpu_result;
   uint32           pc;
   uint32           instruction;
   logic            invalid_address;
   logic            uart_tx;

   row_t       rows[$];
   string      row_names[$];
   uart_byte_t expected_bytes[$];
   uint32      ref_mem [DATA_MEM_WORDS];
   bit         written [DATA_MEM_WORDS];
   uint32      rng_state = 32'd1;
   int         uart_free_row = 0; // first row index at which the transmitter is idle again
   int         frames_expected = 0;
   int         frames_seen = 0;
   int         checks = 0;
   int         errors = 0;
   logic       table_ready = 1'b0;

   platform_top i_dut (
      .clk,
      .arst_n,
      .probe_mem,
      .probe_cmd,
      .probe_result,
      .cpu_cmd,
      .cpu_result,
      .pc,
      .instruction,
      .invalid_address,
      .uart_tx
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic uint32 xorshift(input uint32 x);
      uint32 y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic next_random(output uint32 value);
      rng_state = xorshift(rng_state);
      value = rng_state;
   endtask

   task automatic check(input string name, input uint32 expected, input uint32 actual);
      checks++;
      if (expected !== actual) begin
         errors++;
         $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   function automatic mem_bus_cmd_t make_cmd(input word_addr_t address, input logic rd,
                                             input logic wr, input byte_mask_t mask,
                                             input uint32 data);
      mem_bus_cmd_t c;
      c.address    = address;
      c.mem_read   = rd;
      c.mem_write  = wr;
      c.mask_byte  = mask;
      c.write_data = data;
      return c;
   endfunction

   // expected values come from the reference model as it stands before this row's write
   task automatic add_row(input string name, input logic sel_probe, input mem_bus_cmd_t p_cmd,
                          input mem_bus_cmd_t c_cmd, input uint32 fetch_pc);
      row_t         r;
      mem_bus_cmd_t sel;
      int           offset;
      logic         in_mem;
      logic         in_uart;
      mem_index_t   idx;
      mem_index_t   fetch_idx;
      uint32        bits;
      int           row_idx;
      row_idx   = rows.size();
      sel       = sel_probe ? p_cmd : c_cmd;
      offset    = int'(sel.address) - int'(DATA_MEM_BASE);
      in_mem    = offset >= 0 && offset < DATA_MEM_WORDS;
      in_uart   = sel.address == UART_ADDR;
      idx       = mem_index_t'(offset);
      fetch_idx = fetch_pc[MEM_INDEX_W+1:2];
      r.probe_mem   = sel_probe;
      r.probe_cmd   = p_cmd;
      r.cpu_cmd     = c_cmd;
      r.pc          = fetch_pc;
      r.exp_invalid = (sel.mem_read | sel.mem_write) & ~in_mem & ~in_uart;
      r.chk_data    = 1'b0;
      r.exp_data    = '0;
      if (r.exp_invalid) begin
         r.chk_data = 1'b1;
      end else if (sel.mem_read && in_mem) begin
         r.chk_data = written[idx];
         r.exp_data = ref_mem[idx];
      end else if (sel.mem_read && in_uart) begin
         r.chk_data = 1'b1;
         r.exp_data = uint32'(row_idx < uart_free_row);
      end
      r.chk_instr = written[fetch_idx];
      r.exp_instr = ref_mem[fetch_idx];
      if (sel.mem_write && in_mem) begin
         bits = {{8{sel.mask_byte[3]}}, {8{sel.mask_byte[2]}},
                 {8{sel.mask_byte[1]}}, {8{sel.mask_byte[0]}}};
         ref_mem[idx] = (ref_mem[idx] & ~bits) | (sel.write_data & bits);
         written[idx] = 1'b1;
      end
      if (sel.mem_write && in_uart && row_idx >= uart_free_row) begin
         expected_bytes.push_back(sel.write_data[7:0]);
         frames_expected++;
         uart_free_row = row_idx + FRAME_CYCLES + 1;
      end
      rows.push_back(r);
      row_names.push_back(name);
   endtask

   task automatic probe_write(input string name, input word_addr_t a, input byte_mask_t m,
                              input uint32 d);
      add_row(name, 1'b1, make_cmd(a, 1'b0, 1'b1, m, d), '0, 32'd0);
   endtask

   task automatic probe_read(input string name, input word_addr_t a);
      add_row(name, 1'b1, make_cmd(a, 1'b1, 1'b0, 4'h0, 32'd0), '0, 32'd0);
   endtask

   task automatic cpu_write(input string name, input word_addr_t a, input byte_mask_t m,
                            input uint32 d);
      add_row(name, 1'b0, '0, make_cmd(a, 1'b0, 1'b1, m, d), 32'd0);
   endtask

   task automatic cpu_read(input string name, input word_addr_t a);
      add_row(name, 1'b0, '0, make_cmd(a, 1'b1, 1'b0, 4'h0, 32'd0), 32'd0);
   endtask

   task automatic build_table();
      uint32 d;
      int    first_uart;
      next_random(d);
      probe_write("probe full write w3", 30'd3, 4'hf, d);
      probe_read("probe read w3", 30'd3);
      next_random(d);
      probe_write("probe mask 0101 w3", 30'd3, 4'b0101, d);
      probe_read("probe read w3 after 0101", 30'd3);
      next_random(d);
      probe_write("probe mask 1000 w3", 30'd3, 4'b1000, d);
      probe_read("probe read w3 after 1000", 30'd3);
      next_random(d);
      probe_write("probe full write w10", 30'd10, 4'hf, d);
      next_random(d);
      probe_write("probe mask 0010 w10", 30'd10, 4'b0010, d);
      probe_read("probe read w10", 30'd10);
      next_random(d);
      probe_write("probe write w1", 30'd1, 4'hf, d);
      next_random(d);
      probe_write("probe write w5", 30'd5, 4'hf, d);
      next_random(d);
      probe_write("probe write w1023", 30'd1023, 4'hf, d);
      probe_read("probe read w1023", 30'd1023);
      next_random(d);
      cpu_write("cpu full write w20", 30'd20, 4'hf, d);
      cpu_read("cpu read w20", 30'd20);
      next_random(d);
      cpu_write("cpu mask 0011 w20", 30'd20, 4'b0011, d);
      cpu_read("cpu read w20 after 0011", 30'd20);
      next_random(d);
      add_row("cpu write while probe selected", 1'b1, make_cmd(30'd20, 1'b1, 1'b0, 4'h0, 32'd0),
              make_cmd(30'd20, 1'b0, 1'b1, 4'hf, d), 32'd0);
      cpu_read("cpu read w20 after blocked write", 30'd20);
      add_row("fetch w3", 1'b1, '0, '0, 32'd12);
      add_row("fetch w10", 1'b1, '0, '0, 32'd40);
      add_row("fetch w20", 1'b0, '0, '0, 32'd80);
      add_row("fetch w1023", 1'b1, '0, '0, 32'd4092);
      probe_read("invalid read 0x400", 30'h400);
      next_random(d);
      probe_write("invalid write 0x405", 30'h405, 4'hf, d);
      cpu_read("invalid read 0x7ff", 30'h7ff);
      next_random(d);
      probe_write("invalid write 0x801", 30'h801, 4'hf, d);
      probe_read("invalid read top", 30'h3fffffff);
      add_row("no strobe at 0x400", 1'b1, make_cmd(30'h400, 1'b0, 1'b0, 4'hf, d), '0, 32'd0);
      probe_read("w5 after invalid write", 30'd5);
      probe_read("w1 after invalid write", 30'd1);
      first_uart = rows.size();
      next_random(d);
      probe_write("uart write", UART_ADDR, 4'h1, d);
      probe_read("uart status after write", UART_ADDR);
      cpu_write("uart write while busy", UART_ADDR, 4'h1, 32'h3c);
      while (rows.size() < first_uart + FRAME_CYCLES) begin
         add_row("uart wait", 1'b1, '0, '0, 32'd12);
      end
      probe_read("uart status last busy cycle", UART_ADDR);
      probe_read("uart status after frame", UART_ADDR);
      next_random(d);
      cpu_write("uart second write", UART_ADDR, 4'h1, d);
      cpu_read("uart status second frame", UART_ADDR);
   endtask

   task automatic receive_frame();
      uart_byte_t rx;
      rx = '0;
      repeat (UART_CLKS_PER_BIT / 2) @(negedge clk); // middle of the start bit
      check("uart start bit", 32'd0, uint32'(uart_tx));
      repeat (8) begin
         repeat (UART_CLKS_PER_BIT) @(negedge clk);
         rx = {uart_tx, rx[7:1]}; // lsb arrives first
      end
      repeat (UART_CLKS_PER_BIT) @(negedge clk);
      check("uart stop bit", 32'd1, uint32'(uart_tx));
      if (expected_bytes.size() == 0) begin
         errors++;
         $display("a UART frame arrived with no accepted write behind it");
      end else begin
         check("uart data byte", uint32'(expected_bytes.pop_front()), uint32'(rx));
      end
      frames_seen++;
   endtask

   initial begin
      wait (arst_n);
      forever begin
         @(negedge uart_tx);
         receive_frame();
      end
   end

   initial begin
      wait (table_ready);
      repeat (rows.size() + 2 * FRAME_CYCLES + 20) @(posedge clk);
      $display("timeout: the run did not finish within the expected number of clock cycles");
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      row_t  r;
      uint32 sel_data;
      uint32 other_data;
      arst_n    = 1'b0;
      probe_mem = 1'b0;
      probe_cmd = '0;
      cpu_cmd   = '0;
      pc        = '0;
      build_table();
      table_ready = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      arst_n = 1'b1;
      check("uart_tx after reset", 32'd1, uint32'(uart_tx));
      for (int i = 0; i < rows.size(); i++) begin
         @(posedge clk);
         #DRIVE_DELAY;
         r         = rows[i];
         probe_mem = r.probe_mem;
         probe_cmd = r.probe_cmd;
         cpu_cmd   = r.cpu_cmd;
         pc        = r.pc;
         #SAMPLE_DELAY;
         sel_data   = r.probe_mem ? probe_result.read_data : cpu_result.read_data;
         other_data = r.probe_mem ? cpu_result.read_data : probe_result.read_data;
         if (r.chk_data) check({row_names[i], " read_data"}, r.exp_data, sel_data);
         check({row_names[i], " other master"}, 32'd0, other_data);
         check({row_names[i], " invalid_address"}, uint32'(r.exp_invalid),
               uint32'(invalid_address));
         if (r.chk_instr) check({row_names[i], " instruction"}, r.exp_instr, instruction);
      end
      @(posedge clk);
      #DRIVE_DELAY;
      probe_cmd = '0;
      cpu_cmd   = '0;
      wait (frames_seen >= frames_expected);
      repeat (FRAME_CYCLES + 2) @(posedge clk); // room for a frame that should not come
      check("uart frame count", uint32'(frames_expected), uint32'(frames_seen));
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== platform.f ====
hdl/common_pkg.sv
hdl/bus_interconnect.sv
hdl/data_mem.sv
hdl/uart_tx_port.sv
hdl/platform_top.sv
testbench/tb_platform_top.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_platform_top
FILELIST = platform.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
